// ==== flist.f ====
ccip_pkg.sv
afu_csr_pkg.sv
frame_write_if.sv
csr_capture.sv
frame_release.sv
status_writer.sv
write_arbiter.sv
frame_ring_top.sv
tb_checker.sv
tb_frame_ring.sv

// ==== run.sh ====
#!/bin/sh
# Builds the frame ring testbench with Verilator and runs it once.
# The run counts as passed only if the pass message shows up in its output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_frame_ring \
    || { echo "run.sh: build failed"; exit 1; }

./obj_dir/Vtb_frame_ring | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== tb_frame_ring.sv ====
`timescale 1ns/10ps

module tb_frame_ring;

    localparam int LOG_FRAME_NUMBER = 4;
    localparam int LOG_FRAME_CHUNKS = 3;
    localparam int STATUS_INTERVAL  = 4;
    localparam int CLK_HALF         = 20;
    localparam int NUM_RELEASES     = 300;
    localparam int NUM_DISABLED     = 12;
    // Each release gets 20 cycles, plus room for reset, setup and drain
    localparam int TIMEOUT_CYCLES   = NUM_RELEASES * 20 + 2000;

    logic                               clk;
    logic                               resetb;
    logic                               csr_write;
    afu_csr_pkg::t_csr_addr             csr_addr;
    logic [ccip_pkg::ADDR_WIDTH-1:0]    csr_data;
    logic                               release_frame;
    logic                               wr_almost_full;
    logic                               rdy;
    logic                               wr_valid;
    ccip_pkg::t_tx_header               wr_header;
    logic [ccip_pkg::DATA_WIDTH-1:0]    wr_data;
    afu_csr_pkg::t_afu_debug_rsp        dbg_frame_release;

    logic        finish_req;
    logic        model_idle;
    logic        summary_done;
    int          error_total;
    integer      seed;
    logic [31:0] rnd;
    int          released;
    logic        burst;

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    frame_ring_top #(
        .LOG_FRAME_NUMBER (LOG_FRAME_NUMBER),
        .LOG_FRAME_CHUNKS (LOG_FRAME_CHUNKS),
        .STATUS_INTERVAL  (STATUS_INTERVAL)
    ) u_frame_ring_top (
        .clk               (clk),
        .resetb            (resetb),
        .csr_write         (csr_write),
        .csr_addr          (csr_addr),
        .csr_data          (csr_data),
        .release_frame     (release_frame),
        .wr_almost_full    (wr_almost_full),
        .rdy               (rdy),
        .wr_valid          (wr_valid),
        .wr_header         (wr_header),
        .wr_data           (wr_data),
        .dbg_frame_release (dbg_frame_release)
    );

    tb_checker #(
        .LOG_FRAME_NUMBER (LOG_FRAME_NUMBER),
        .LOG_FRAME_CHUNKS (LOG_FRAME_CHUNKS),
        .STATUS_INTERVAL  (STATUS_INTERVAL)
    ) u_tb_checker (
        .clk               (clk),
        .resetb            (resetb),
        .csr_write         (csr_write),
        .csr_addr          (csr_addr),
        .csr_data          (csr_data),
        .release_frame     (release_frame),
        .wr_almost_full    (wr_almost_full),
        .rdy               (rdy),
        .wr_valid          (wr_valid),
        .wr_header         (wr_header),
        .wr_data           (wr_data),
        .dbg_frame_release (dbg_frame_release),
        .finish_req        (finish_req),
        .model_idle        (model_idle),
        .summary_done      (summary_done),
        .error_total       (error_total)
    );

    // Inputs change 2 ns after the rising edge so the DUT samples settled values
    task automatic next_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic write_csr(input afu_csr_pkg::t_csr_addr addr, input logic [31:0] data);
        next_slot();
        csr_write = 1'b1;
        csr_addr  = addr;
        csr_data  = data;
        next_slot();
        csr_write = 1'b0;
    endtask

    // Fill the pending count to all ones with the channel blocked, then let it drain
    // The burst stops at one release per ring slot even if rdy never falls
    task automatic fill_credits();
        next_slot();
        wr_almost_full = 1'b1;
        while (rdy && released < (1 << LOG_FRAME_NUMBER))
        begin
            release_frame = 1'b1;
            released++;
            next_slot();
        end
        release_frame = 1'b0;
        repeat (3) next_slot();
        wr_almost_full = 1'b0;
    endtask

    // Releases come sparse or in dense bursts, and only while rdy is high
    task automatic random_releases();
        while (released < NUM_RELEASES)
        begin
            next_slot();
            rnd = $random(seed);
            if (rnd[7:4] == 4'd0)
                burst = ~burst;
            if (rnd[11:9] == 3'd0)
                wr_almost_full = ~wr_almost_full;
            if (rdy && (burst ? (rnd[1:0] != 2'd0) : (rnd[15:12] == 4'd0)))
            begin
                release_frame = 1'b1;
                released++;
            end
            else
            begin
                release_frame = 1'b0;
            end
        end
        next_slot();
        release_frame  = 1'b0;
        wr_almost_full = 1'b0;
    endtask

    initial
    begin
        seed           = 32'ha00b;
        resetb         = 1'b0;
        csr_write      = 1'b0;
        csr_addr       = afu_csr_pkg::CSR_ENABLE;
        csr_data       = '0;
        release_frame  = 1'b0;
        wr_almost_full = 1'b0;
        finish_req     = 1'b0;
        released       = 0;
        burst          = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        resetb = 1'b1;
        rnd = $random(seed);
        write_csr(afu_csr_pkg::CSR_FRAME_BASE, rnd);
        rnd = $random(seed);
        write_csr(afu_csr_pkg::CSR_STATUS_ADDR, rnd);
        // While the AFU is disabled these pulses must have no effect at all
        for (int i = 0; i < NUM_DISABLED; i++)
        begin
            next_slot();
            release_frame = 1'b1;
            next_slot();
            release_frame = 1'b0;
        end
        write_csr(afu_csr_pkg::CSR_ENABLE, 32'd1);
        fill_credits();
        random_releases();
        // The model reports idle once every clear and status write has come out
        while (!model_idle)
            @(posedge clk);
        repeat (8) @(posedge clk);
        finish_req = 1'b1;
        wait (summary_done);
        if (error_total == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * 2 * CLK_HALF);
        $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker
    #(
    parameter int LOG_FRAME_NUMBER = 4,
    parameter int LOG_FRAME_CHUNKS = 3,
    parameter int STATUS_INTERVAL  = 4
    )
    (
    input  logic                                clk,
    input  logic                                resetb,
    input  logic                                csr_write,
    input  afu_csr_pkg::t_csr_addr              csr_addr,
    input  logic [ccip_pkg::ADDR_WIDTH-1:0]     csr_data,
    input  logic                                release_frame,
    input  logic                                wr_almost_full,
    input  logic                                rdy,
    input  logic                                wr_valid,
    input  ccip_pkg::t_tx_header                wr_header,
    input  logic [ccip_pkg::DATA_WIDTH-1:0]     wr_data,
    input  afu_csr_pkg::t_afu_debug_rsp         dbg_frame_release,
    input  logic                                finish_req,
    output logic                                model_idle,
    output logic                                summary_done,
    output int                                  error_total
    );

    localparam int LOW_BITS  = LOG_FRAME_NUMBER + LOG_FRAME_CHUNKS;
    localparam int NUM_TESTS = 6;
    localparam int T_CLEAR   = 0;
    localparam int T_COUNT   = 1;
    localparam int T_BP      = 2;
    localparam int T_GATE    = 3;
    localparam int T_CREDIT  = 4;
    localparam int T_DEBUG   = 5;

    string test_name [NUM_TESTS];
    int    checks    [NUM_TESTS];
    int    errors    [NUM_TESTS];

    // Model copy of the CSR state, updated one cycle after each write like the DUT
    logic        m_enable;
    logic [31:0] m_base;
    logic [31:0] m_status_addr;

    // Enabled releases so far and clear writes seen on the channel
    int                          rel_count;
    int                          clears_seen;
    int                          status_seen;
    int                          pend;
    logic [LOG_FRAME_NUMBER-1:0] next_frame;
    logic [31:0]                 last_offset;
    logic [31:0]                 exp_addr;

    // Status request state for the coming cycle, and the same state one cycle back
    // A write seen now was granted one cycle earlier, so it is checked against the old copy
    logic        stat_pend;
    logic        stat_pend_prev;
    logic [31:0] stat_lat;
    logic [31:0] stat_lat_prev;
    logic [31:0] last_status;
    logic        bnd_prev;
    logic        boundary;
    logic        rel_en;
    logic        af_prev;
    logic        rdy_low_seen;

    task automatic check_value(input int test, input string sig,
                               input logic [63:0] exp, input logic [63:0] act);
        checks[test]++;
        if (exp !== act)
        begin
            errors[test]++;
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, sig, exp, act);
        end
    endtask

    task automatic report_problem(input int test, input string msg);
        checks[test]++;
        errors[test]++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    initial
    begin
        test_name[T_CLEAR]  = "clear_writes";
        test_name[T_COUNT]  = "write_counts";
        test_name[T_BP]     = "back_pressure";
        test_name[T_GATE]   = "enable_gating";
        test_name[T_CREDIT] = "credit_limit";
        test_name[T_DEBUG]  = "debug_response";
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            checks[i] = 0;
            errors[i] = 0;
        end
    end

    // Sampling on the falling edge sees inputs and outputs settled for the whole cycle
    always @(negedge clk)
    begin
        if (!resetb)
        begin
            m_enable       = 1'b0;
            m_base         = '0;
            m_status_addr  = '0;
            rel_count      = 0;
            clears_seen    = 0;
            status_seen    = 0;
            next_frame     = '0;
            last_offset    = '0;
            stat_pend      = 1'b0;
            stat_pend_prev = 1'b0;
            stat_lat       = '0;
            stat_lat_prev  = '0;
            last_status    = '0;
            bnd_prev       = 1'b0;
            af_prev        = 1'b0;
            rdy_low_seen   = 1'b0;
            model_idle     = 1'b1;
        end
        else
        begin
            // Almost full in the previous cycle must have blocked any grant
            if (af_prev)
                check_value(T_BP, "wr_valid", 64'd0, 64'(wr_valid));

            if (wr_valid && wr_header.request_type == ccip_pkg::WR_THRU)
            begin
                // Chunk 0 of the next frame in ring order, under the frame base
                exp_addr = {m_base[31:LOW_BITS], next_frame, LOG_FRAME_CHUNKS'(0)};
                check_value(T_CLEAR, "wr_header.address", 64'(exp_addr),
                            64'(wr_header.address));
                check_value(T_CLEAR, "wr_data", 64'd0, wr_data);
                if (clears_seen >= rel_count)
                    report_problem(T_GATE, "clear write issued with no enabled release pending");
                clears_seen++;
                last_offset = 32'({next_frame, LOG_FRAME_CHUNKS'(0)});
                next_frame  = next_frame + 1'b1;
            end
            else if (wr_valid && wr_header.request_type == ccip_pkg::WR_LINE)
            begin
                check_value(T_COUNT, "wr_header.address", 64'(m_status_addr),
                            64'(wr_header.address));
                check_value(T_COUNT, "wr_data", 64'(stat_lat_prev), wr_data);
                if (!stat_pend_prev)
                    report_problem(T_COUNT, "status write issued with no status request pending");
                if (status_seen > 0 && wr_data[31:0] <= last_status)
                    report_problem(T_COUNT, "status count did not increase");
                last_status = wr_data[31:0];
                status_seen++;
                // A boundary in the grant cycle keeps the request alive with the new count
                if (!bnd_prev)
                    stat_pend = 1'b0;
            end
            else if (wr_valid)
            begin
                report_problem(T_CLEAR, "write with an unknown request type");
            end

            // Pending clears in this cycle decide rdy
            pend = rel_count - clears_seen;
            check_value(T_CREDIT, "rdy", 64'(pend != ((1 << LOG_FRAME_NUMBER) - 1)), 64'(rdy));
            if (!rdy)
                rdy_low_seen = 1'b1;

            check_value(T_GATE, "dbg.frames_released", 64'(rel_count[15:0]),
                        64'(dbg_frame_release.frames_released));
            check_value(T_DEBUG, "dbg.last_clear_offset", 64'(last_offset),
                        64'(dbg_frame_release.last_clear_offset));
            check_value(T_DEBUG, "dbg.unexpected_write", 64'd0,
                        64'(dbg_frame_release.unexpected_write));

            // Every STATUS_INTERVAL enabled releases latch a fresh count for reporting
            rel_en   = release_frame && m_enable;
            boundary = rel_en && ((rel_count + 1) % STATUS_INTERVAL == 0);
            stat_pend_prev = stat_pend;
            stat_lat_prev  = stat_lat;
            bnd_prev       = boundary;
            if (boundary)
            begin
                stat_pend = 1'b1;
                stat_lat  = 32'(rel_count + 1);
            end
            if (rel_en)
                rel_count++;

            af_prev = wr_almost_full;
            if (csr_write && csr_addr == afu_csr_pkg::CSR_ENABLE)
                m_enable = csr_data[0];
            else if (csr_write && csr_addr == afu_csr_pkg::CSR_FRAME_BASE)
                m_base = csr_data;
            else if (csr_write && csr_addr == afu_csr_pkg::CSR_STATUS_ADDR)
                m_status_addr = csr_data;

            model_idle = (clears_seen == rel_count) && !stat_pend;
        end
    end

    // Closing checks once the stimulus has drained, then one line per test
    initial
    begin
        summary_done = 1'b0;
        error_total  = 0;
        wait (finish_req);
        check_value(T_COUNT, "clear write count", 64'(rel_count), 64'(clears_seen));
        check_value(T_COUNT, "status request pending", 64'd0, 64'(stat_pend));
        if (status_seen == 0)
            report_problem(T_COUNT, "no status write was seen");
        if (!rdy_low_seen)
            report_problem(T_CREDIT, "rdy never went low during the almost-full burst");
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            if (checks[i] == 0)
                report_problem(i, "test made no checks");
            $display("test %-15s %0d checks, %0d errors", test_name[i], checks[i], errors[i]);
            error_total += errors[i];
        end
        $display("summary: %0d tests, %0d errors, %0d clear writes, %0d status writes",
                 NUM_TESTS, error_total, clears_seen, status_seen);
        summary_done = 1'b1;
    end

endmodule

// ==== frame_ring_top.sv ====
`timescale 1ns/10ps

module frame_ring_top
    #(
    parameter int LOG_FRAME_NUMBER = 4,
    parameter int LOG_FRAME_CHUNKS = 3,
    parameter int STATUS_INTERVAL  = 4
    )
    (
    input  logic                                clk,
    input  logic                                resetb,
    input  logic                                csr_write,
    input  afu_csr_pkg::t_csr_addr              csr_addr,
    input  logic [ccip_pkg::ADDR_WIDTH-1:0]     csr_data,
    input  logic                                release_frame,
    input  logic                                wr_almost_full,
    output logic                                rdy,
    output logic                                wr_valid,
    output ccip_pkg::t_tx_header                wr_header,
    output logic [ccip_pkg::DATA_WIDTH-1:0]     wr_data,
    output afu_csr_pkg::t_afu_debug_rsp         dbg_frame_release
    );

    afu_csr_pkg::t_csr_afu_state csr_state;
    logic                        release_pulse;

    // One link per writer into the arbiter
    frame_write_if clear_wr ();
    frame_write_if status_wr ();

    csr_capture u_csr_capture (
        .clk           (clk),
        .resetb        (resetb),
        .csr_write     (csr_write),
        .csr_addr      (csr_addr),
        .csr_data      (csr_data),
        .release_frame (release_frame),
        .csr_state     (csr_state),
        .release_pulse (release_pulse)
    );

    frame_release #(
        .LOG_FRAME_NUMBER (LOG_FRAME_NUMBER),
        .LOG_FRAME_CHUNKS (LOG_FRAME_CHUNKS)
    ) u_frame_release (
        .clk               (clk),
        .resetb            (resetb),
        .rdy               (rdy),
        .csr_state         (csr_state),
        .release_pulse     (release_pulse),
        .clear_wr          (clear_wr),
        .dbg_frame_release (dbg_frame_release)
    );

    status_writer #(
        .STATUS_INTERVAL (STATUS_INTERVAL)
    ) u_status_writer (
        .clk           (clk),
        .resetb        (resetb),
        .csr_state     (csr_state),
        .release_pulse (release_pulse),
        .status_wr     (status_wr)
    );

    write_arbiter u_write_arbiter (
        .clk            (clk),
        .resetb         (resetb),
        .clear_wr       (clear_wr),
        .status_wr      (status_wr),
        .wr_almost_full (wr_almost_full),
        .wr_valid       (wr_valid),
        .wr_header      (wr_header),
        .wr_data        (wr_data)
    );

endmodule

// ==== write_arbiter.sv ====
`timescale 1ns/10ps

module write_arbiter
    (
    input  logic                                clk,
    input  logic                                resetb,
    frame_write_if.arbiter                      clear_wr,
    frame_write_if.arbiter                      status_wr,
    input  logic                                wr_almost_full,
    output logic                                wr_valid,
    output ccip_pkg::t_tx_header                wr_header,
    output logic [ccip_pkg::DATA_WIDTH-1:0]     wr_data
    );

    // Which requester wins when both ask in the same cycle
    typedef enum logic {
        PRIO_CLEAR  = 1'b0,
        PRIO_STATUS = 1'b1
    } t_prio;

    t_prio prio;
    logic  clear_grant;
    logic  status_grant;

    // Nothing is granted while the channel is almost full, requests simply wait
    always_comb
    begin
        clear_grant  = 1'b0;
        status_grant = 1'b0;
        if (!wr_almost_full)
        begin
            if (clear_wr.request && (!status_wr.request || prio == PRIO_CLEAR))
                clear_grant = 1'b1;
            else if (status_wr.request)
                status_grant = 1'b1;
        end
    end

    assign clear_wr.grant  = clear_grant;
    assign status_wr.grant = status_grant;

    // The requester just served drops to the back of the line
    always_ff @(posedge clk)
    begin
        if (!resetb)
            prio <= PRIO_CLEAR;
        else if (clear_grant)
            prio <= PRIO_STATUS;
        else if (status_grant)
            prio <= PRIO_CLEAR;
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
            wr_valid <= 1'b0;
        else
            wr_valid <= clear_grant || status_grant;
    end

    // Header and data are only meaningful alongside wr_valid
    always_ff @(posedge clk)
    begin
        if (status_grant)
        begin
            wr_header <= status_wr.header;
            wr_data   <= status_wr.data;
        end
        else
        begin
            wr_header <= clear_wr.header;
            wr_data   <= clear_wr.data;
        end
    end

    // Only one write fits on the channel per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!resetb)
        !(clear_wr.grant && status_wr.grant))
        else $error("write_arbiter: both requesters granted in one cycle");

endmodule

// ==== status_writer.sv ====
`timescale 1ns/10ps

module status_writer
    #(
    parameter int STATUS_INTERVAL = 4
    )
    (
    input  logic                            clk,
    input  logic                            resetb,
    input  afu_csr_pkg::t_csr_afu_state     csr_state,
    input  logic                            release_pulse,
    frame_write_if.requester                status_wr
    );

    localparam int INTERVAL_WIDTH = $clog2(STATUS_INTERVAL + 1);

    // Running count of enabled releases since reset
    logic [31:0] release_count;

    // Position inside the current interval, reaching STATUS_INTERVAL-1 just before a boundary
    logic [INTERVAL_WIDTH-1:0] interval_count;
    logic                      boundary;

    // Count captured at the latest boundary, which is what gets written out
    logic [31:0] status_count;
    logic        status_pending;

    assign boundary = release_pulse &&
                      (interval_count == INTERVAL_WIDTH'(STATUS_INTERVAL - 1));

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            release_count  <= '0;
            interval_count <= '0;
            status_pending <= 1'b0;
        end
        else
        begin
            if (release_pulse)
            begin
                release_count <= release_count + 32'd1;
                interval_count <= boundary ? '0 : interval_count + 1'b1;
            end
            // A new boundary wins over a grant, since it brings a fresh count to report
            if (boundary)
                status_pending <= 1'b1;
            else if (status_wr.grant)
                status_pending <= 1'b0;
        end
    end

    // The payload register needs no reset, it is only read while the request is up
    always_ff @(posedge clk)
    begin
        // Back-to-back boundaries merge and the newer count replaces the older one
        if (boundary)
            status_count <= release_count + 32'd1;
    end

    assign status_wr.request = status_pending;

    always_comb
    begin
        status_wr.header              = '0;
        status_wr.header.request_type = ccip_pkg::WR_LINE;
        status_wr.header.address      = csr_state.status_addr;
        status_wr.header.mdata        = '0;
        status_wr.data                = ccip_pkg::DATA_WIDTH'(status_count);
    end

    a_status_grant: assert property (@(posedge clk) disable iff (!resetb)
        status_wr.grant |-> status_wr.request)
        else $error("status_writer: status write granted without a request");

endmodule

// ==== frame_release.sv ====
`timescale 1ns/10ps

module frame_release
    #(
    parameter int LOG_FRAME_NUMBER = 4,
    parameter int LOG_FRAME_CHUNKS = 3
    )
    (
    input  logic                            clk,
    input  logic                            resetb,
    output logic                            rdy,
    input  afu_csr_pkg::t_csr_afu_state     csr_state,
    input  logic                            release_pulse,
    frame_write_if.requester                clear_wr,
    output afu_csr_pkg::t_afu_debug_rsp     dbg_frame_release
    );

    // Address bits below the frame base come from the frame number and chunk index
    localparam int LOW_BITS = LOG_FRAME_NUMBER + LOG_FRAME_CHUNKS;

    // Next frame in ring order whose header gets cleared
    logic [LOG_FRAME_NUMBER-1:0] frame_number_clear;

    // Releases accepted but not yet written back
    logic [LOG_FRAME_NUMBER-1:0] frames_to_be_cleared;
    logic [LOG_FRAME_NUMBER-1:0] frames_to_be_cleared_next;

    // Debug state
    logic [31:0] dbg_last_clear_offset;
    logic [15:0] dbg_frames_released;
    logic        unexpected_write;
    logic        unexpected_write_next;

    // The pending counter would wrap on one more release, so hold software off
    assign rdy = (frames_to_be_cleared != '1);

    // Ask for the channel as long as any frame is waiting to be cleared
    assign clear_wr.request = (frames_to_be_cleared != '0);

    // The clear goes to chunk 0 of the frame, where the header with the valid bit lives
    always_comb
    begin
        clear_wr.header              = '0;
        clear_wr.header.request_type = ccip_pkg::WR_THRU;
        clear_wr.header.address      = {csr_state.frame_base[ccip_pkg::ADDR_WIDTH-1:LOW_BITS],
                                        frame_number_clear, LOG_FRAME_CHUNKS'(0)};
        clear_wr.header.mdata        = '0;
        // All zero data wipes the whole header including the valid bit
        clear_wr.data                = '0;
    end

    // A release and a grant in the same cycle cancel out
    always_comb
    begin
        frames_to_be_cleared_next = frames_to_be_cleared;
        if (release_pulse)
            frames_to_be_cleared_next = frames_to_be_cleared_next + 1'b1;
        if (clear_wr.grant)
            frames_to_be_cleared_next = frames_to_be_cleared_next - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            frames_to_be_cleared <= '0;
            frame_number_clear   <= '0;
        end
        else
        begin
            frames_to_be_cleared <= frames_to_be_cleared_next;
            // Each granted clear moves on to the next frame, wrapping around the ring
            if (clear_wr.grant)
                frame_number_clear <= frame_number_clear + 1'b1;
        end
    end

    // A grant with nothing pending would clear a frame software still owns
    assign unexpected_write_next = clear_wr.grant && !clear_wr.request;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            unexpected_write      <= 1'b0;
            dbg_last_clear_offset <= '0;
            dbg_frames_released   <= '0;
        end
        else
        begin
            // Sticky so software can spot it long after the event
            if (unexpected_write_next)
                unexpected_write <= 1'b1;
            if (clear_wr.grant)
                dbg_last_clear_offset <= 32'({frame_number_clear, LOG_FRAME_CHUNKS'(0)});
            if (release_pulse)
                dbg_frames_released <= dbg_frames_released + 16'd1;
        end
    end

    always_comb
    begin
        dbg_frame_release                   = '0;
        dbg_frame_release.last_clear_offset = dbg_last_clear_offset;
        dbg_frame_release.frames_released   = dbg_frames_released;
        dbg_frame_release.unexpected_write  = unexpected_write;
    end

    // The arbiter must only grant what was asked for
    a_grant_has_request: assert property (@(posedge clk) disable iff (!resetb)
        !unexpected_write_next)
        else $error("frame_release: clear write granted without a request");

    // Software must respect rdy or the pending count overflows
    a_release_when_rdy: assert property (@(posedge clk) disable iff (!resetb)
        release_pulse |-> rdy)
        else $error("frame_release: frame released while rdy was low");

endmodule

// ==== csr_capture.sv ====
`timescale 1ns/10ps

module csr_capture
    (
    input  logic                                clk,
    input  logic                                resetb,
    input  logic                                csr_write,
    input  afu_csr_pkg::t_csr_addr              csr_addr,
    input  logic [ccip_pkg::ADDR_WIDTH-1:0]     csr_data,
    input  logic                                release_frame,
    output afu_csr_pkg::t_csr_afu_state         csr_state,
    output logic                                release_pulse
    );

    // Each CSR write lands one cycle later in the selected field
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            csr_state <= '0;
        end
        else if (csr_write)
        begin
            case (csr_addr)
                afu_csr_pkg::CSR_ENABLE:
                begin
                    // Only bit 0 of the data word matters for enable
                    csr_state.enable <= csr_data[0];
                end
                afu_csr_pkg::CSR_FRAME_BASE:
                begin
                    csr_state.frame_base <= csr_data;
                end
                afu_csr_pkg::CSR_STATUS_ADDR:
                begin
                    csr_state.status_addr <= csr_data;
                end
                default:
                begin
                    // Unknown addresses leave the state alone
                    csr_state <= csr_state;
                end
            endcase
        end
    end

    // Releases only count while software has the AFU enabled
    assign release_pulse = release_frame && csr_state.enable;

    // Software must never write outside the decoded CSR space
    a_csr_addr_known: assert property (@(posedge clk) disable iff (!resetb)
        csr_write |-> (csr_addr inside {afu_csr_pkg::CSR_ENABLE,
                                        afu_csr_pkg::CSR_FRAME_BASE,
                                        afu_csr_pkg::CSR_STATUS_ADDR}))
        else $error("csr_capture: write to unknown CSR address %0h", csr_addr);

endmodule

// ==== frame_write_if.sv ====
`timescale 1ns/10ps

// One requester's path into the write arbiter
// The request is a level held while work remains, the grant is a one-cycle pulse
interface frame_write_if;

    logic                               request;
    ccip_pkg::t_tx_header               header;
    logic [ccip_pkg::DATA_WIDTH-1:0]    data;
    logic                               grant;

    // A block that has writes to issue
    modport requester (
        output request,
        output header,
        output data,
        input  grant
    );

    // The block that picks which requester owns the channel
    modport arbiter (
        input  request,
        input  header,
        input  data,
        output grant
    );

endinterface

// ==== afu_csr_pkg.sv ====
package afu_csr_pkg;

    // Word addresses of the CSRs that software writes during setup
    typedef enum logic [3:0] {
        CSR_ENABLE      = 4'h0,
        CSR_FRAME_BASE  = 4'h1,
        CSR_STATUS_ADDR = 4'h2
    } t_csr_addr;

    // Configuration state built from the CSR writes
    // The low bits of frame_base are dropped by the frame geometry
    typedef struct packed {
        logic                               enable;
        logic [ccip_pkg::ADDR_WIDTH-1:0]    frame_base;
        logic [ccip_pkg::ADDR_WIDTH-1:0]    status_addr;
    } t_csr_afu_state;

    // Debug word reported by the frame release logic, 64 bits in total
    typedef struct packed {
        logic [31:0]    last_clear_offset;
        logic [15:0]    frames_released;
        logic [14:0]    reserved;
        logic           unexpected_write;
    } t_afu_debug_rsp;

endpackage

// ==== ccip_pkg.sv ====
package ccip_pkg;

    // Width of a cache-line address on the write channel
    parameter int ADDR_WIDTH = 32;

    // Width of the write data carried with each request
    parameter int DATA_WIDTH = 64;

    // Width of the requester tag returned with completions
    parameter int MDATA_WIDTH = 8;

    // Write opcodes understood by the memory channel
    // Write-through is used for the frame clears so the line does not linger in a cache
    // A full line write is used for the status record
    typedef enum logic [1:0] {
        WR_THRU = 2'h1,
        WR_LINE = 2'h2
    } t_request_type;

    // Header that travels with every write on the channel
    typedef struct packed {
        t_request_type            request_type;
        logic [ADDR_WIDTH-1:0]    address;
        logic [MDATA_WIDTH-1:0]   mdata;
    } t_tx_header;

endpackage
